/* hw/lights_macros.svh */
`ifndef LIGHTS_MACROS_SVH
`define LIGHTS_MACROS_SVH

// cells per side of the square light grid.
`define GRID_SIZE 16

// width of a decimal coordinate while it is being parsed.
`define POS_WIDTH 12

// width of one input character.
`define CHAR_WIDTH 8

// bits needed to index one row or one column of the grid.
`define CELL_WIDTH ($clog2(`GRID_SIZE))

// the lit count must be able to hold every cell of the grid.
`define COUNT_WIDTH ($clog2(`GRID_SIZE * `GRID_SIZE + 1))

`endif

/* hw/lights_pkg.sv */
`include "lights_macros.svh"

package lights_pkg;

    // encoding follows the decoder's letter-pair detection.
    // turn_on is all ones, so bit 1 alone separates set from toggle/clear.
    typedef enum logic [1:0] {
        turn_off = 2'b00,
        toggle   = 2'b01,
        turn_on  = 2'b11
    } op_t;

    // which coordinate field the decoder is currently collecting.
    typedef enum logic [1:0] {
        start_row_s = 2'd0,
        start_col_s = 2'd1,
        end_row_s   = 2'd2,
        end_col_s   = 2'd3
    } parse_state_t;

    // one rectangle instruction, normalized so start is never past end.
    typedef struct packed {
        op_t                    op;
        logic [`CELL_WIDTH-1:0] start_row;
        logic [`CELL_WIDTH-1:0] start_col;
        logic [`CELL_WIDTH-1:0] end_row;
        logic [`CELL_WIDTH-1:0] end_col;
    } rect_instr_t;

endpackage

/* hw/instr_if.sv */
interface instr_if
    import lights_pkg::*;
();

    // valid is a single-cycle pulse; instr holds until the next line.
    logic        valid;
    rect_instr_t instr;

    // high while a rectangle is being swept.
    logic        busy;

    modport decoder (
        output valid,
        output instr
    );

    modport sweep (
        input  valid,
        input  instr,
        output busy
    );

endinterface

/* hw/line_decoder.sv */
`include "lights_macros.svh"

module line_decoder
    import lights_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   byte_valid,
    input  logic [`CHAR_WIDTH-1:0] byte_data,
    output logic                   end_of_file,
    instr_if.decoder               instr_out
);

    localparam logic [`CHAR_WIDTH-1:0] char_nul   = 8'h00;
    localparam logic [`CHAR_WIDTH-1:0] char_lf    = 8'h0a;
    localparam logic [`CHAR_WIDTH-1:0] char_space = 8'h20;
    localparam logic [`CHAR_WIDTH-1:0] char_comma = 8'h2c;
    localparam logic [`CHAR_WIDTH-1:0] char_zero  = 8'h30;
    localparam logic [`CHAR_WIDTH-1:0] char_nine  = 8'h39;
    localparam logic [`CHAR_WIDTH-1:0] char_f     = 8'h66;
    localparam logic [`CHAR_WIDTH-1:0] char_n     = 8'h6e;
    localparam logic [`CHAR_WIDTH-1:0] char_o     = 8'h6f;
    localparam logic [`CHAR_WIDTH-1:0] char_t     = 8'h74;

    parse_state_t           field_state;
    logic [`CHAR_WIDTH-1:0] prev_char;
    logic [`CHAR_WIDTH-1:0] digit_char;
    logic [`POS_WIDTH-1:0]  position;
    op_t                    op;
    logic                   cur_digit;
    logic                   prev_digit;
    logic                   line_end;
    logic                   number_done;

    logic [`CELL_WIDTH-1:0] start_row;
    logic [`CELL_WIDTH-1:0] start_col;
    logic [`CELL_WIDTH-1:0] end_row;
    logic [`CELL_WIDTH-1:0] end_col;
    logic [`CELL_WIDTH-1:0] cur_start_row;
    logic [`CELL_WIDTH-1:0] cur_start_col;
    logic [`CELL_WIDTH-1:0] cur_end_row;
    logic [`CELL_WIDTH-1:0] cur_end_col;

    function automatic logic is_digit(logic [`CHAR_WIDTH-1:0] c);
        return (c >= char_zero) && (c <= char_nine);
    endfunction

    assign cur_digit  = is_digit(byte_data);
    assign prev_digit = is_digit(prev_char);
    assign digit_char = byte_data - char_zero;
    assign line_end   = byte_valid && (byte_data == char_lf);

    // a number is complete when a separator follows its last digit.
    assign number_done = byte_valid && prev_digit &&
                         (byte_data == char_comma || byte_data == char_space ||
                          byte_data == char_lf);

    // the field values as they will be once this byte is taken, so the
    // final coordinate is already part of the instruction on the line feed.
    always_comb begin
        cur_start_row = start_row;
        cur_start_col = start_col;
        cur_end_row   = end_row;
        cur_end_col   = end_col;
        if (number_done) begin
            case (field_state)
                start_row_s: cur_start_row = position[`CELL_WIDTH-1:0];
                start_col_s: cur_start_col = position[`CELL_WIDTH-1:0];
                end_row_s:   cur_end_row   = position[`CELL_WIDTH-1:0];
                default:     cur_end_col   = position[`CELL_WIDTH-1:0];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_char   <= char_nul;
            field_state <= start_row_s;
        end else if (byte_valid) begin
            prev_char <= byte_data;
            if (byte_data == char_lf) begin
                field_state <= start_row_s;
            end else begin
                case (field_state)
                    start_row_s: if (byte_data == char_comma) field_state <= start_col_s;
                    start_col_s: if (byte_data == char_space) field_state <= end_row_s;
                    end_row_s:   if (byte_data == char_comma) field_state <= end_col_s;
                    default:     field_state <= end_col_s;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_valid) begin
            if (cur_digit) begin
                position <= prev_digit ? position * `POS_WIDTH'(10) + `POS_WIDTH'(digit_char)
                                       : `POS_WIDTH'(digit_char);
            end
            case ({prev_char, byte_data})
                {char_o, char_f}: op <= turn_off;
                {char_t, char_o}: op <= toggle;
                {char_o, char_n}: op <= turn_on;
                default: ;
            endcase
            start_row <= cur_start_row;
            start_col <= cur_start_col;
            end_row   <= cur_end_row;
            end_col   <= cur_end_col;
        end
    end

    // the rectangle goes out with its corners ordered low to high.
    always_ff @(posedge clk) begin
        if (line_end) begin
            instr_out.instr.op        <= op;
            instr_out.instr.start_row <= (cur_start_row <= cur_end_row) ? cur_start_row
                                                                         : cur_end_row;
            instr_out.instr.end_row   <= (cur_start_row <= cur_end_row) ? cur_end_row
                                                                         : cur_start_row;
            instr_out.instr.start_col <= (cur_start_col <= cur_end_col) ? cur_start_col
                                                                         : cur_end_col;
            instr_out.instr.end_col   <= (cur_start_col <= cur_end_col) ? cur_end_col
                                                                         : cur_start_col;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            instr_out.valid <= 1'b0;
            end_of_file     <= 1'b0;
        end else begin
            instr_out.valid <= line_end;
            if (byte_valid && byte_data == char_nul) begin
                end_of_file <= 1'b1;
            end
        end
    end

endmodule

/* hw/sweep_fsm.sv */
`include "lights_macros.svh"

module sweep_fsm
    import lights_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    instr_if.sweep                 instr_in,
    input  logic                   last_cell,
    output logic                   start,
    output logic [`CELL_WIDTH-1:0] start_row,
    output logic [`CELL_WIDTH-1:0] start_col,
    output logic [`CELL_WIDTH-1:0] end_row,
    output logic [`CELL_WIDTH-1:0] end_col,
    output op_t                    op
);

    typedef enum logic {
        state_idle  = 1'b0,
        state_sweep = 1'b1
    } sweep_state_t;

    sweep_state_t state;

    // start is taken straight from the pulse so the scanner loads on the
    // same edge that moves this machine into sweep.
    assign start = (state == state_idle) && instr_in.valid;

    // the scanner captures the bounds itself when start is high.
    assign start_row = instr_in.instr.start_row;
    assign start_col = instr_in.instr.start_col;
    assign end_row   = instr_in.instr.end_row;
    assign end_col   = instr_in.instr.end_col;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= state_idle;
        end else begin
            case (state)
                state_idle: begin
                    if (start) begin
                        state <= state_sweep;
                    end
                end
                default: begin
                    if (last_cell) begin
                        state <= state_idle;
                    end
                end
            endcase
        end
    end

    // the operation is held for the grid through the whole sweep.
    always_ff @(posedge clk) begin
        if (start) begin
            op <= instr_in.instr.op;
        end
    end

    assign instr_in.busy = (state == state_sweep);

    // the byte source has to hold off while a rectangle is in flight.
    assert property (@(posedge clk) disable iff (reset)
        instr_in.valid |-> !instr_in.busy);

endmodule

/* hw/rect_scanner.sv */
`include "lights_macros.svh"

module rect_scanner (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic [`CELL_WIDTH-1:0] start_row,
    input  logic [`CELL_WIDTH-1:0] start_col,
    input  logic [`CELL_WIDTH-1:0] end_row,
    input  logic [`CELL_WIDTH-1:0] end_col,
    output logic                   cell_valid,
    output logic [`CELL_WIDTH-1:0] row,
    output logic [`CELL_WIDTH-1:0] col,
    output logic                   last_cell
);

    logic [`CELL_WIDTH-1:0] first_row;
    logic [`CELL_WIDTH-1:0] first_col;
    logic [`CELL_WIDTH-1:0] last_row;
    logic [`CELL_WIDTH-1:0] last_col;

    assign last_cell = cell_valid && (row == last_row) && (col == last_col);

    always_ff @(posedge clk) begin
        if (start) begin
            first_row <= start_row;
            first_col <= start_col;
            last_row  <= end_row;
            last_col  <= end_col;
        end
    end

    // the walk is row-major and the column wraps back to the left edge at each row end.
    always_ff @(posedge clk) begin
        if (reset) begin
            cell_valid <= 1'b0;
            row        <= '0;
            col        <= '0;
        end else if (start) begin
            cell_valid <= 1'b1;
            row        <= start_row;
            col        <= start_col;
        end else if (cell_valid) begin
            if (last_cell) begin
                cell_valid <= 1'b0;
            end else if (col == last_col) begin
                col <= first_col;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        cell_valid |-> (row >= first_row) && (row <= last_row) &&
                       (col >= first_col) && (col <= last_col));

endmodule

/* hw/light_grid.sv */
`include "lights_macros.svh"

module light_grid
    import lights_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cell_valid,
    input  logic [`CELL_WIDTH-1:0]  row,
    input  logic [`CELL_WIDTH-1:0]  col,
    input  op_t                     op,
    output logic [`COUNT_WIDTH-1:0] lit_count
);

    // one bit per light, indexed [row][col].
    logic [`GRID_SIZE-1:0][`GRID_SIZE-1:0] cells;

    logic old_bit;
    logic new_bit;
    logic turned_on;
    logic turned_off;

    assign old_bit = cells[row][col];

    always_comb begin
        case (op)
            turn_on:  new_bit = 1'b1;
            toggle:   new_bit = !old_bit;
            default:  new_bit = 1'b0;
        endcase
    end

    assign turned_on  = cell_valid && new_bit && !old_bit;
    assign turned_off = cell_valid && !new_bit && old_bit;

    always_ff @(posedge clk) begin
        if (reset) begin
            cells <= '0;
        end else if (cell_valid) begin
            cells[row][col] <= new_bit;
        end
    end

    // the count tracks each change instead of summing the whole grid.
    always_ff @(posedge clk) begin
        if (reset) begin
            lit_count <= '0;
        end else if (turned_on) begin
            lit_count <= lit_count + 1'b1;
        end else if (turned_off) begin
            lit_count <= lit_count - 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        lit_count <= (`GRID_SIZE * `GRID_SIZE));

endmodule

/* hw/light_array_top.sv */
`include "lights_macros.svh"

module light_array_top
    import lights_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    byte_valid,
    input  logic [`CHAR_WIDTH-1:0]  byte_data,
    output logic                    busy,
    output logic                    end_of_file,
    output logic [`COUNT_WIDTH-1:0] lit_count
);

    instr_if instr_bus ();

    logic                   start;
    logic [`CELL_WIDTH-1:0] start_row;
    logic [`CELL_WIDTH-1:0] start_col;
    logic [`CELL_WIDTH-1:0] end_row;
    logic [`CELL_WIDTH-1:0] end_col;
    logic                   cell_valid;
    logic [`CELL_WIDTH-1:0] row;
    logic [`CELL_WIDTH-1:0] col;
    logic                   last_cell;
    op_t                    op;

    line_decoder u_line_decoder (
        .clk         (clk),
        .reset       (reset),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .end_of_file (end_of_file),
        .instr_out   (instr_bus.decoder)
    );

    sweep_fsm u_sweep_fsm (
        .clk       (clk),
        .reset     (reset),
        .instr_in  (instr_bus.sweep),
        .last_cell (last_cell),
        .start     (start),
        .start_row (start_row),
        .start_col (start_col),
        .end_row   (end_row),
        .end_col   (end_col),
        .op        (op)
    );

    rect_scanner u_rect_scanner (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .start_row  (start_row),
        .start_col  (start_col),
        .end_row    (end_row),
        .end_col    (end_col),
        .cell_valid (cell_valid),
        .row        (row),
        .col        (col),
        .last_cell  (last_cell)
    );

    light_grid u_light_grid (
        .clk        (clk),
        .reset      (reset),
        .cell_valid (cell_valid),
        .row        (row),
        .col        (col),
        .op         (op),
        .lit_count  (lit_count)
    );

    assign busy = instr_bus.busy;

endmodule

/* test/lights_tb.sv */
`include "lights_macros.svh"

module lights_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period   = 8;
    localparam int reset_cycles = 2;
    localparam int slack_cycles = 200;
    localparam string data_path = "test/lights_testdata.txt";

    logic                    clk;
    logic                    reset;
    logic                    byte_valid;
    logic [`CHAR_WIDTH-1:0]  byte_data;
    logic                    busy;
    logic                    end_of_file;
    logic [`COUNT_WIDTH-1:0] lit_count;

    // one entry per instruction record of the data file.
    string rec_op[$];
    int    rec_r0[$];
    int    rec_c0[$];
    int    rec_r1[$];
    int    rec_c1[$];
    int    rec_expect[$];

    bit          model[`GRID_SIZE][`GRID_SIZE];
    int          model_count = 0;
    int          error_count = 0;
    int          check_count = 0;
    int          watchdog_cycles = 0;
    logic [31:0] rand_state = 32'd82629;

    light_array_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .busy        (busy),
        .end_of_file (end_of_file),
        .lit_count   (lit_count)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // picks 0 to 3 idle cycles to leave in front of a byte.
    function automatic int next_gap();
        rand_state = xorshift32(rand_state);
        return int'(rand_state[1:0]);
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("ERR %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    function automatic string op_text(input string word);
        if (word == "on") return "turn on";
        if (word == "off") return "turn off";
        return "toggle";
    endfunction

    function automatic string format_line(input int idx);
        return $sformatf("%s %0d,%0d through %0d,%0d", op_text(rec_op[idx]),
                         rec_r0[idx], rec_c0[idx], rec_r1[idx], rec_c1[idx]);
    endfunction

    function automatic int span(input int a, input int b);
        return (a > b) ? a - b + 1 : b - a + 1;
    endfunction

    task automatic load_records();
        int    fd;
        int    fields;
        int    r0, c0, r1, c1, expected;
        string line;
        string word;
        fd = $fopen(data_path, "r");
        if (fd == 0) begin
            error_count++;
            $display("could not open the data file %s", data_path);
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.getc(0) == "#") continue;
            fields = $sscanf(line, "%s %d %d %d %d %d", word, r0, c0, r1, c1, expected);
            if (fields <= 0) continue;
            if (fields != 6 || !(word == "on" || word == "off" || word == "toggle")) begin
                error_count++;
                $display("malformed record in the data file: %s", line);
                continue;
            end
            rec_op.push_back(word);
            rec_r0.push_back(r0);
            rec_c0.push_back(c0);
            rec_r1.push_back(r1);
            rec_c1.push_back(c1);
            rec_expect.push_back(expected);
            // each byte takes up to four cycles with its gap and the sweep follows.
            watchdog_cycles += (format_line(rec_op.size() - 1).len() + 1) * 4 +
                               span(r0, r1) * span(c0, c1) + 10;
        end
        $fclose(fd);
    endtask

    // the reference grid applies the same rule to every cell of the rectangle.
    function automatic void apply_to_model(input int idx);
        int r;
        int c;
        bit next;
        for (r = 0; r < `GRID_SIZE; r++) begin
            for (c = 0; c < `GRID_SIZE; c++) begin
                if (r >= ((rec_r0[idx] < rec_r1[idx]) ? rec_r0[idx] : rec_r1[idx]) &&
                    r <= ((rec_r0[idx] > rec_r1[idx]) ? rec_r0[idx] : rec_r1[idx]) &&
                    c >= ((rec_c0[idx] < rec_c1[idx]) ? rec_c0[idx] : rec_c1[idx]) &&
                    c <= ((rec_c0[idx] > rec_c1[idx]) ? rec_c0[idx] : rec_c1[idx])) begin
                    if (rec_op[idx] == "on") next = 1'b1;
                    else if (rec_op[idx] == "off") next = 1'b0;
                    else next = !model[r][c];
                    if (next && !model[r][c]) model_count++;
                    if (!next && model[r][c]) model_count--;
                    model[r][c] = next;
                end
            end
        end
    endfunction

    // enters on a falling edge and returns on the falling edge after the byte is taken.
    task automatic send_byte(input logic [`CHAR_WIDTH-1:0] value);
        repeat (next_gap()) @(negedge clk);
        byte_valid = 1'b1;
        byte_data  = value;
        @(negedge clk);
        byte_valid = 1'b0;
    endtask

    task automatic send_line(input string text);
        int i;
        for (i = 0; i < text.len(); i++) begin
            send_byte(text.getc(i));
        end
        send_byte(8'h0a);
    endtask

    task automatic wait_sweep_done();
        while (busy !== 1'b1) @(negedge clk);
        while (busy !== 1'b0) @(negedge clk);
    endtask

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles + slack_cycles) @(posedge clk);
        $display("timeout after %0d cycles, the DUT stopped responding",
                 watchdog_cycles + slack_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : stimulus
        int    idx;
        string text;
        string name;
        reset      = 1'b1;
        byte_valid = 1'b0;
        byte_data  = '0;
        load_records();
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        check_value("after reset lit_count", 0, lit_count);
        check_value("after reset busy", 0, busy);
        check_value("after reset end_of_file", 0, end_of_file);

        for (idx = 0; idx < rec_op.size(); idx++) begin
            text = format_line(idx);
            name = $sformatf("record %0d (%s)", idx + 1, text);
            send_line(text);
            wait_sweep_done();
            apply_to_model(idx);
            check_value({name, " file count"}, model_count, rec_expect[idx]);
            check_value({name, " lit_count"}, model_count, lit_count);
            check_value({name, " end_of_file"}, 0, end_of_file);
        end

        send_byte(8'h00);
        check_value("end_of_file after NUL", 1, end_of_file);
        if (rec_expect.size() > 0) begin
            check_value("final lit_count", rec_expect[rec_expect.size() - 1], lit_count);
        end else begin
            error_count++;
            $display("the data file held no instruction records");
        end

        $display("errors: %0d of %0d checks", error_count, check_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* test/lights_testdata.txt */
# columns: operation (on, off, toggle), first row, first col, second row, second col,
# and the lit count expected once that line has been swept.
on 1 2 5 7 30
toggle 3 5 8 10 48
off 0 0 0 15 48
off 4 6 4 6 48
on 0 0 0 15 64
off 2 0 2 15 58
toggle 9 9 9 9 59
on 10 12 7 3 86
toggle 0 0 15 15 170
off 5 5 12 12 147
off 15 0 15 15 131
toggle 14 3 15 4 131

/* list.f */
+incdir+hw
hw/lights_pkg.sv
hw/instr_if.sv
hw/line_decoder.sv
hw/sweep_fsm.sv
hw/rect_scanner.sv
hw/light_grid.sv
hw/light_array_top.sv
test/lights_tb.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module lights_tb -o lights_sim

sim_output=$(./obj_dir/lights_sim)
echo "$sim_output"

if echo "$sim_output" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1
